/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Mdir obj_dir
TOP       = scaler_tb
FILELIST  = files.f
PASS_MSG  = Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* files.f */
+incdir+include
src/scaler_video_pkg.sv
src/scaler_filter_pkg.sv
src/scaler_coe_rom.sv
src/scaler_line_store.sv
src/scaler_tap_filter.sv
src/scaler_v.sv
verification/scaler_assert.sv
verification/scaler_tb.sv

/* include/scaler_consts.svh */
`ifndef SCALER_CONSTS_SVH
`define SCALER_CONSTS_SVH

// luma sample width
`define SCALER_DATA_WIDTH 8

// coefficient width, 512 is unity gain
`define SCALER_COE_WIDTH 10

// longest supported input line in pixels
`define SCALER_LINE_SIZE_MAX 64

// ring depth, four taps plus the line being written
`define SCALER_NUM_BUFS 5

// kernel phases and index width
`define SCALER_PHASES 32
`define SCALER_PHASE_BITS 5

// idle cycles between two output pixels
`define SCALER_SPARSE 2

// one input line in 4.12 fixed point
`define SCALER_ONE 4096

// first output line of a frame sits on input line 1
`define SCALER_POS_START 4096

`endif

/* src/scaler_coe_rom.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scaler_consts.svh"

module scaler_coe_rom (
    input  logic                      clk,
    input  scaler_filter_pkg::phase_t phase_i,
    output scaler_filter_pkg::coe_t   coe0_o,
    output scaler_filter_pkg::coe_t   coe1_o,
    output scaler_filter_pkg::coe_t   coe2_o,
    output scaler_filter_pkg::coe_t   coe3_o
);
    import scaler_filter_pkg::*;

    localparam int PH = `SCALER_PHASES;
    // unity gain in coefficient units
    localparam int S  = 1 << (`SCALER_COE_WIDTH - 1);

    // catmull-rom weight, t = p/PH, all terms scaled by PH^3
    // c0 and c3 are magnitudes of negative lobes
    function automatic coe_t coe_calc(input int tap, input int p);
        int q;
        int num;
        int den;
        q   = PH - p;
        den = 2 * PH * PH * PH;
        case (tap)
            0:       num = p * q * q;
            1:       num = 3 * p * p * p - 5 * p * p * PH + 2 * PH * PH * PH;
            2:       num = -3 * p * p * p + 4 * p * p * PH + p * PH * PH;
            default: num = p * p * q;
        endcase
        // round to nearest, every numerator is non-negative
        return coe_t'((S * num + den / 2) / den);
    endfunction

    coe_t rom [4][PH];

    // table fixed at elaboration
    for (genvar k = 0; k < 4; k++) begin : g_tap
        for (genvar p = 0; p < PH; p++) begin : g_phase
            assign rom[k][p] = coe_calc(k, p);
        end
    end

    // registered read, lines up with the line buffer read
    always_ff @(posedge clk) begin
        coe0_o <= rom[0][phase_i];
        coe1_o <= rom[1][phase_i];
        coe2_o <= rom[2][phase_i];
        coe3_o <= rom[3][phase_i];
    end

endmodule

`default_nettype wire

/* src/scaler_filter_pkg.sv */
`default_nettype none

`include "scaler_consts.svh"

package scaler_filter_pkg;

    // fixed point layout of line positions
    localparam int POS_WIDTH = 24;
    localparam int POS_FRAC  = 12;

    // line position, 12 fraction bits
    typedef logic [POS_WIDTH-1:0] pos_t;

    // scale step, 4.12 unsigned
    typedef logic [15:0] step_t;

    // coefficient magnitude, sign is fixed per tap
    typedef logic [`SCALER_COE_WIDTH-1:0] coe_t;

    // kernel phase index
    typedef logic [`SCALER_PHASE_BITS-1:0] phase_t;

    // pixel times coefficient
    typedef logic [`SCALER_DATA_WIDTH+`SCALER_COE_WIDTH-1:0] prod_t;

    // signed tap sum, two guard bits over a product
    typedef logic signed [`SCALER_DATA_WIDTH+`SCALER_COE_WIDTH+1:0] acc_t;

    // half an lsb of the output before the shift
    localparam int ACC_ROUND = 1 << (`SCALER_COE_WIDTH - 2);
    // result lsb position inside the sum
    localparam int ACC_SHIFT = `SCALER_COE_WIDTH - 1;

endpackage

`default_nettype wire

/* src/scaler_line_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scaler_consts.svh"

module scaler_line_store (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      wr_en_i,
    input  scaler_video_pkg::col_t    wr_col_i,
    input  scaler_video_pkg::pixel_t  wr_pix_i,
    input  logic                      line_done_i,
    input  logic                      frame_start_i,
    input  scaler_video_pkg::col_t    rd_col_i,
    output scaler_video_pkg::pixel_t  tap0_o,
    output scaler_video_pkg::pixel_t  tap1_o,
    output scaler_video_pkg::pixel_t  tap2_o,
    output scaler_video_pkg::pixel_t  tap3_o
);
    import scaler_video_pkg::*;

    localparam int NB = `SCALER_NUM_BUFS;

    // five line memories
    pixel_t mem [NB][`SCALER_LINE_SIZE_MAX];

    // slot taking the incoming line
    buf_sel_t wr_slot;

    pixel_t tap_q [4];

    // slot written k+1 lines before the current one
    function automatic buf_sel_t slot_back(input buf_sel_t s, input int k);
        int v;
        v = int'(s) - 1 - k;
        if (v < 0) begin
            v = v + NB;
        end
        return buf_sel_t'(v);
    endfunction

    // ring pointer, restarts on each frame
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_slot <= '0;
        end else if (frame_start_i) begin
            wr_slot <= '0;
        end else if (line_done_i) begin
            wr_slot <= (wr_slot == buf_sel_t'(NB - 1)) ? '0 : wr_slot + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_slot][wr_col_i] <= wr_pix_i;
        end
    end

    // tap 0 is the newest finished line, tap 3 the oldest
    for (genvar k = 0; k < 4; k++) begin : g_rd
        always_ff @(posedge clk) begin
            tap_q[k] <= mem[slot_back(wr_slot, k)][rd_col_i];
        end
    end

    assign tap0_o = tap_q[0];
    assign tap1_o = tap_q[1];
    assign tap2_o = tap_q[2];
    assign tap3_o = tap_q[3];

endmodule

`default_nettype wire

/* src/scaler_tap_filter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scaler_consts.svh"

module scaler_tap_filter (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  scaler_video_pkg::pixel_t  tap0_i,
    input  scaler_video_pkg::pixel_t  tap1_i,
    input  scaler_video_pkg::pixel_t  tap2_i,
    input  scaler_video_pkg::pixel_t  tap3_i,
    input  scaler_filter_pkg::coe_t   coe0_i,
    input  scaler_filter_pkg::coe_t   coe1_i,
    input  scaler_filter_pkg::coe_t   coe2_i,
    input  scaler_filter_pkg::coe_t   coe3_i,
    input  logic                      pix_en_i,
    input  logic                      line_i,
    input  logic                      vs_i,
    output scaler_video_pkg::pixel_t  pix_o,
    output logic                      de_o,
    output logic                      hs_o,
    output logic                      vs_o
);
    import scaler_filter_pkg::*;

    localparam int DW = `SCALER_DATA_WIDTH;

    prod_t prod_q [4];
    acc_t  sum_q;

    // flag delay lines, bit 3 leaves the filter
    logic [3:0] en_sr;
    logic [3:0] line_sr;
    logic [3:0] vs_sr;

    always_ff @(posedge clk) begin
        // stage 1, one product per tap
        prod_q[0] <= tap0_i * coe0_i;
        prod_q[1] <= tap1_i * coe1_i;
        prod_q[2] <= tap2_i * coe2_i;
        prod_q[3] <= tap3_i * coe3_i;
        // stage 2, inner lines add, outer lobes subtract
        sum_q <= acc_t'(prod_q[1]) + acc_t'(prod_q[2])
               - acc_t'(prod_q[0]) - acc_t'(prod_q[3]) + acc_t'(ACC_ROUND);
        // stage 3, clamp to pixel range
        if (sum_q < 0) begin
            pix_o <= '0;
        end else if (sum_q[$bits(acc_t)-2 : ACC_SHIFT+DW] != '0) begin
            pix_o <= '1;
        end else begin
            pix_o <= sum_q[ACC_SHIFT +: DW];
        end
    end

    // tap read stage plus three arithmetic stages
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            en_sr   <= '0;
            line_sr <= '0;
            vs_sr   <= '0;
        end else begin
            en_sr   <= {en_sr[2:0], pix_en_i};
            line_sr <= {line_sr[2:0], line_i};
            vs_sr   <= {vs_sr[2:0], vs_i};
        end
    end

    assign de_o = en_sr[3];
    assign hs_o = line_sr[3];
    assign vs_o = vs_sr[3];

endmodule

`default_nettype wire

/* src/scaler_v.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scaler_consts.svh"

module scaler_v (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  scaler_video_pkg::pixel_t  pix_i,
    input  logic                      de_i,
    input  logic                      hs_i,
    input  logic                      vs_i,
    input  scaler_filter_pkg::step_t  scale_step_i,
    input  scaler_video_pkg::col_t    line_size_i,
    output scaler_video_pkg::pixel_t  pix_o,
    output logic                      de_o,
    output logic                      hs_o,
    output logic                      vs_o
);
    import scaler_video_pkg::*;
    import scaler_filter_pkg::*;

    localparam int SPARSE_W = $clog2(`SCALER_SPARSE + 2);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CALC,
        ST_READ
    } state_t;

    // input pipe
    pixel_t s1_pix;
    pixel_t s2_pix;
    logic   s1_de;
    logic   s1_hs;
    logic   s1_vs;
    logic   s2_de;
    logic   s2_hs;
    logic   s2_vs;
    logic   hs_rise;
    logic   vs_fall;
    logic   de_fall;

    col_t   wr_col;
    pos_t   in_pos;
    pos_t   out_pos;
    pos_t   need_pos;
    step_t  step_q;
    col_t   size_q;
    col_t   rd_col;
    logic   frame_ok;
    state_t state;
    phase_t phase_q;
    logic   pix_en;
    logic   line_act;

    logic [SPARSE_W-1:0] sparse_cnt;

    pixel_t tap0, tap1, tap2, tap3;
    coe_t   coe0, coe1, coe2, coe3;

    // pixel payload, two stages
    always_ff @(posedge clk) begin
        s1_pix <= pix_i;
        s2_pix <= s1_pix;
    end

    // sync flags, edges land in stage two
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            s1_de   <= 1'b0;
            s1_hs   <= 1'b0;
            s1_vs   <= 1'b0;
            s2_de   <= 1'b0;
            s2_hs   <= 1'b0;
            s2_vs   <= 1'b0;
            hs_rise <= 1'b0;
            vs_fall <= 1'b0;
            de_fall <= 1'b0;
        end else begin
            s1_de   <= de_i;
            s1_hs   <= hs_i;
            s1_vs   <= vs_i;
            s2_de   <= s1_de;
            s2_hs   <= s1_hs;
            s2_vs   <= s1_vs;
            hs_rise <= s1_hs & ~s2_hs;
            vs_fall <= s2_vs & ~s1_vs;
            // first cycle after the last active pixel
            de_fall <= s2_de & ~s1_de;
        end
    end

    // write column, cleared between lines
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_col <= '0;
        end else if (s2_de) begin
            wr_col <= wr_col + 1'b1;
        end else if (hs_rise || de_fall || vs_fall) begin
            wr_col <= '0;
        end
    end

    // stored lines in position units
    // frame_ok holds off output until a full frame start is seen
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            in_pos   <= '0;
            frame_ok <= 1'b0;
        end else if (vs_fall) begin
            in_pos   <= '0;
            frame_ok <= 1'b1;
        end else if (de_fall) begin
            in_pos <= in_pos + pos_t'(`SCALER_ONE);
        end
    end

    // line n+2 must be stored before line n can be filtered
    assign need_pos = out_pos + pos_t'(2 * `SCALER_ONE);

    assign line_act = (state == ST_READ);
    assign pix_en   = line_act && (sparse_cnt == SPARSE_W'(`SCALER_SPARSE));

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state      <= ST_IDLE;
            out_pos    <= pos_t'(`SCALER_POS_START);
            step_q     <= step_t'(`SCALER_ONE);
            size_q     <= '0;
            rd_col     <= '0;
            sparse_cnt <= '0;
            phase_q    <= '0;
        end else if (vs_fall) begin
            // new frame, take the configuration
            state      <= ST_IDLE;
            out_pos    <= pos_t'(`SCALER_POS_START);
            step_q     <= scale_step_i;
            size_q     <= line_size_i;
            rd_col     <= '0;
            sparse_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (frame_ok && (in_pos > need_pos)) begin
                        // fraction bits 11..7 pick the phase
                        phase_q <= out_pos[POS_FRAC-1 -: `SCALER_PHASE_BITS];
                        state   <= ST_CALC;
                    end
                end
                ST_CALC: begin
                    rd_col     <= '0;
                    sparse_cnt <= '0;
                    state      <= ST_READ;
                end
                ST_READ: begin
                    if (pix_en) begin
                        sparse_cnt <= '0;
                        rd_col     <= rd_col + 1'b1;
                        // last pixel, step to next output line
                        if (rd_col == size_q) begin
                            out_pos <= out_pos + pos_t'(step_q);
                            state   <= ST_IDLE;
                        end
                    end else begin
                        sparse_cnt <= sparse_cnt + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    scaler_line_store u_line_store (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .wr_en_i       (s2_de),
        .wr_col_i      (wr_col),
        .wr_pix_i      (s2_pix),
        .line_done_i   (de_fall),
        .frame_start_i (vs_fall),
        .rd_col_i      (rd_col),
        .tap0_o        (tap0),
        .tap1_o        (tap1),
        .tap2_o        (tap2),
        .tap3_o        (tap3)
    );

    scaler_coe_rom u_coe_rom (
        .clk     (clk),
        .phase_i (phase_q),
        .coe0_o  (coe0),
        .coe1_o  (coe1),
        .coe2_o  (coe2),
        .coe3_o  (coe3)
    );

    // rom weight k belongs to line n-1+k, tap k holds line n+2-k
    scaler_tap_filter u_tap_filter (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .tap0_i   (tap0),
        .tap1_i   (tap1),
        .tap2_i   (tap2),
        .tap3_i   (tap3),
        .coe0_i   (coe3),
        .coe1_i   (coe2),
        .coe2_i   (coe1),
        .coe3_i   (coe0),
        .pix_en_i (pix_en),
        .line_i   (line_act),
        .vs_i     (s2_vs),
        .pix_o    (pix_o),
        .de_o     (de_o),
        .hs_o     (hs_o),
        .vs_o     (vs_o)
    );

endmodule

`default_nettype wire

/* src/scaler_video_pkg.sv */
`default_nettype none

`include "scaler_consts.svh"

package scaler_video_pkg;

    // one luma sample
    typedef logic [`SCALER_DATA_WIDTH-1:0] pixel_t;

    // pixel index inside a line
    // also carries the line size (count minus one)
    typedef logic [$clog2(`SCALER_LINE_SIZE_MAX)-1:0] col_t;

    // slot number in the line buffer ring
    typedef logic [$clog2(`SCALER_NUM_BUFS)-1:0] buf_sel_t;

endpackage

`default_nettype wire

/* verification/scaler_assert.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scaler_consts.svh"

module scaler_assert (
    input logic clk,
    input logic rst_n_i,
    input logic de_i,
    input logic hs_i
);

    // pixels only inside an output line window
    a_de_in_line: assert property (
        @(posedge clk) disable iff (!rst_n_i) de_i |-> hs_i
    ) else $error("de_o high while hs_o is low");

    // sparse cadence, no pulse within SPARSE cycles of the last one
    for (genvar k = 1; k <= `SCALER_SPARSE; k++) begin : g_gap
        a_gap: assert property (
            @(posedge clk) disable iff (!rst_n_i) de_i |-> !$past(de_i, k)
        ) else $error("de_o pulses closer than the sparse spacing");
    end

endmodule

bind scaler_tap_filter scaler_assert u_assert (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .de_i    (de_o),
    .hs_i    (hs_o)
);

`default_nettype wire

/* verification/scaler_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scaler_consts.svh"

module scaler_tb;
    import scaler_video_pkg::*;
    import scaler_filter_pkg::*;

    localparam int LINES        = 10;
    localparam int LINE_W       = 16;
    // long horizontal blanking so two output lines fit in one input line
    localparam int LINE_PERIOD  = 160;
    localparam int VBLANK_LINES = 3;
    localparam int NUM_FRAMES   = 6;
    localparam int LIMIT_CYCLES = 2 * NUM_FRAMES * (LINES + VBLANK_LINES) * LINE_PERIOD + 200;
    // reset lands while the output line after the aborted input line runs
    localparam int ABORT_CYCLE  = 48;
    // vs path, two input stages plus four filter stages
    localparam int VS_DELAY     = 6;

    logic   clk;
    logic   rst_n_i;
    pixel_t pix_i;
    logic   de_i;
    logic   hs_i;
    logic   vs_i;
    step_t  scale_step_i;
    col_t   line_size_i;
    pixel_t pix_o;
    logic   de_o;
    logic   hs_o;
    logic   vs_o;

    logic [15:0] lfsr;
    pixel_t      frame_mem [LINES][LINE_W];
    // expected output pixels in emission order
    pixel_t      exp_pix [$];
    int          exp_lines;
    int          got_lines;
    int          line_cnt;
    int          last_de;
    int          cycle;
    logic        hs_prev;
    logic [VS_DELAY-1:0] vs_hist;
    int          pix_errs;
    int          cnt_errs;
    int          proto_errs;

    scaler_v uut (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .pix_i        (pix_i),
        .de_i         (de_i),
        .hs_i         (hs_i),
        .vs_i         (vs_i),
        .scale_step_i (scale_step_i),
        .line_size_i  (line_size_i),
        .pix_o        (pix_o),
        .de_o         (de_o),
        .hs_o         (hs_o),
        .vs_o         (vs_o)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // one lfsr step per pixel bit
    task automatic rand_pixel(output pixel_t v);
        v = '0;
        for (int b = 0; b < `SCALER_DATA_WIDTH; b++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[`SCALER_DATA_WIDTH-2:0], lfsr[0]};
        end
    endtask

    // catmull-rom weight magnitude, 512 is unity
    function automatic int coe_model(input int tap, input int phase);
        real t;
        real c;
        t = real'(phase) / 32.0;
        case (tap)
            0:       c = 512.0 * t * (1.0 - t) * (1.0 - t) / 2.0;
            1:       c = 512.0 * (3.0 * t * t * t - 5.0 * t * t + 2.0) / 2.0;
            2:       c = 512.0 * (-3.0 * t * t * t + 4.0 * t * t + t) / 2.0;
            default: c = 512.0 * t * t * (1.0 - t) / 2.0;
        endcase
        return $rtoi(c + 0.5);
    endfunction

    // weight k sits on input line n-1+k, outer lines subtract
    function automatic pixel_t model_pixel(input int n, input int phase, input int col);
        int acc;
        acc = 256;
        acc = acc - int'(frame_mem[n - 1][col]) * coe_model(0, phase);
        acc = acc + int'(frame_mem[n][col]) * coe_model(1, phase);
        acc = acc + int'(frame_mem[n + 1][col]) * coe_model(2, phase);
        acc = acc - int'(frame_mem[n + 2][col]) * coe_model(3, phase);
        if (acc < 0) begin
            return '0;
        end
        if ((acc >>> 9) > 255) begin
            return '1;
        end
        return pixel_t'(acc >>> 9);
    endfunction

    task automatic check_pixel(input pixel_t got, input pixel_t exp);
        if (got !== exp) begin
            pix_errs++;
            $display("error at %0t: output line %0d got %0d, expected %0d",
                     $time, got_lines, got, exp);
        end
    endtask

    task automatic check_count(input col_t got, input col_t exp, input string what);
        if (got !== exp) begin
            cnt_errs++;
            $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            proto_errs++;
            $display("error at %0t: %s is %0b, expected %0b", $time, what, got, exp);
        end
    endtask

    // mode 0 random pixels, mode 1 line pairs of 0 and 255 for clamping
    task automatic gen_frame(input int mode);
        pixel_t v;
        for (int k = 0; k < LINES; k++) begin
            for (int c = 0; c < LINE_W; c++) begin
                if (mode == 1) begin
                    v = ((k / 2) % 2 == 1) ? 8'd255 : 8'd0;
                end else begin
                    rand_pixel(v);
                end
                frame_mem[k][c] = v;
            end
        end
    endtask

    // walk the position rule over the whole frame
    task automatic build_expected(input int step);
        int pos;
        int n;
        int ph;
        exp_lines = 0;
        pos = `SCALER_POS_START;
        while ((pos >> 12) + 2 <= LINES - 1) begin
            n  = pos >> 12;
            ph = (pos >> 7) % `SCALER_PHASES;
            for (int c = 0; c < LINE_W; c++) begin
                exp_pix.push_back(model_pixel(n, ph, c));
            end
            exp_lines++;
            pos = pos + step;
        end
    endtask

    // first len cycles of input line k
    task automatic drive_line(input int k, input int len);
        for (int c = 0; c < len; c++) begin
            @(posedge clk);
            hs_i  <= (c < 4);
            de_i  <= (c >= 8) && (c < 8 + LINE_W);
            pix_i <= ((c >= 8) && (c < 8 + LINE_W)) ? frame_mem[k][c - 8] : '0;
        end
    endtask

    task automatic vblank_wait();
        @(posedge clk);
        vs_i <= 1'b1;
        hs_i <= 1'b0;
        de_i <= 1'b0;
        repeat (VBLANK_LINES * LINE_PERIOD) @(posedge clk);
    endtask

    // frame done, every expected line must have come out
    task automatic close_frame();
        check_count(col_t'(got_lines), col_t'(exp_lines), "output lines per frame");
        if (exp_pix.size() != 0) begin
            proto_errs++;
            $display("missing output: %0d expected pixels never appeared", exp_pix.size());
        end
        exp_pix.delete();
        got_lines = 0;
    endtask

    task automatic reset_mid_frame();
        @(posedge clk);
        rst_n_i <= 1'b0;
        de_i    <= 1'b0;
        hs_i    <= 1'b0;
        vs_i    <= 1'b1;
        repeat (2) @(posedge clk);
        // partial frame is dropped
        exp_pix.delete();
        got_lines = 0;
        if (de_o !== 1'b0 || hs_o !== 1'b0 || vs_o !== 1'b0) begin
            proto_errs++;
            $display("output flags not cleared by reset at %0t", $time);
        end
        rst_n_i <= 1'b1;
        repeat (VBLANK_LINES * LINE_PERIOD) @(posedge clk);
    endtask

    // abort_line below zero runs the full frame
    task automatic run_frame(input int step, input int mode, input int abort_line);
        gen_frame(mode);
        build_expected(step);
        @(posedge clk);
        scale_step_i <= step_t'(step);
        line_size_i  <= col_t'(LINE_W - 1);
        vs_i         <= 1'b0;
        repeat (4) @(posedge clk);
        for (int k = 0; k < LINES; k++) begin
            if (k == abort_line) begin
                drive_line(k, ABORT_CYCLE);
                reset_mid_frame();
                return;
            end
            drive_line(k, LINE_PERIOD);
        end
        vblank_wait();
        close_frame();
    endtask

    // output side checker
    always @(posedge clk) begin : output_monitor
        pixel_t e;
        cycle = cycle + 1;
        if (!rst_n_i) begin
            hs_prev  = 1'b0;
            line_cnt = 0;
            vs_hist  = '0;
        end else begin
            // vs_o follows vs_i through the whole pipe
            check_flag(vs_o, vs_hist[VS_DELAY-1], "vs_o");
            vs_hist = {vs_hist[VS_DELAY-2:0], vs_i};
            if (de_o && !hs_o) begin
                proto_errs++;
                $display("de_o high outside an output line at %0t", $time);
            end
            if (de_o) begin
                if (line_cnt > 0 && (cycle - last_de) != `SCALER_SPARSE + 1) begin
                    proto_errs++;
                    $display("de_o pulses %0d cycles apart at %0t", cycle - last_de, $time);
                end
                last_de  = cycle;
                line_cnt = line_cnt + 1;
                if (exp_pix.size() == 0) begin
                    proto_errs++;
                    $display("unexpected output pixel at %0t, no line was due", $time);
                end else begin
                    e = exp_pix.pop_front();
                    check_pixel(pix_o, e);
                end
            end
            // end of an output line window
            if (hs_prev && !hs_o) begin
                check_count(col_t'(line_cnt - 1), line_size_i, "line size of output line");
                got_lines = got_lines + 1;
                line_cnt  = 0;
            end
            hs_prev = hs_o;
        end
    end

    initial begin : watchdog
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin : stimulus
        lfsr         = 16'd65412;
        rst_n_i      = 1'b0;
        pix_i        = '0;
        de_i         = 1'b0;
        hs_i         = 1'b0;
        vs_i         = 1'b1;
        scale_step_i = step_t'(`SCALER_ONE);
        line_size_i  = col_t'(LINE_W - 1);
        exp_lines    = 0;
        got_lines    = 0;
        line_cnt     = 0;
        last_de      = 0;
        cycle        = 0;
        hs_prev      = 1'b0;
        vs_hist      = '0;
        pix_errs     = 0;
        cnt_errs     = 0;
        proto_errs   = 0;
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;
        repeat (LINE_PERIOD) @(posedge clk);
        // unity, upscale, downscale
        run_frame(4096, 0, -1);
        run_frame(2048, 0, -1);
        run_frame(6144, 0, -1);
        // clamping at phase 16
        run_frame(2048, 1, -1);
        // reset inside the output line after input line 5, then a clean frame
        run_frame(4096, 0, 5);
        run_frame(2048, 0, -1);
        $display("errors: %0d pixel, %0d count, %0d protocol", pix_errs, cnt_errs, proto_errs);
        if (pix_errs == 0 && cnt_errs == 0 && proto_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
